/* hw/mipsIsaPkg.sv */
package mipsIsaPkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    // Operand and address width of the core
    localparam int dataWidth = 32;

    // Register number, 32 GPRs
    localparam int regAddrWidth = 5;

    ////////////////////////////////////////////////////////////
    // Instruction word fields
    ////////////////////////////////////////////////////////////

    // Major opcode sits in the top six bits
    localparam int opcodeWidth = 6;
    localparam int opcodeLsb   = 26;

    // Register fields for I and R formats
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;

    // Low half holds the immediate, low six bits the funct
    localparam int immWidth   = 16;
    localparam int functWidth = 6;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Supported opcodes, standard MIPS-I values
    typedef enum logic [opcodeWidth-1:0] {
        opRtype = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    // R-type funct codes
    typedef enum logic [functWidth-1:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnNor = 6'h27,
        fnSlt = 6'h2a
    } functE;

endpackage

/* hw/exCtrlPkg.sv */
package exCtrlPkg;

    ////////////////////////////////////////////////////////////
    // Control field layout between the pipeline blocks
    ////////////////////////////////////////////////////////////

    // Write-back field {regWrite, memToReg}
    localparam int wbWidth       = 2;
    localparam int wbRegWriteBit = 1;
    localparam int wbMemToRegBit = 0;

    // Memory field {memRead, memWrite, branch}
    localparam int memWidth       = 3;
    localparam int memReadBit     = 2;
    localparam int memWriteBit    = 1;
    localparam int memBranchBit   = 0;

    ////////////////////////////////////////////////////////////
    // ALU encodings
    ////////////////////////////////////////////////////////////

    // Operation class from the main decoder
    typedef enum logic [2:0] {
        aluOpAdd   = 3'd0,
        aluOpSub   = 3'd1,
        aluOpFunct = 3'd2,
        aluOpAnd   = 3'd3,
        aluOpOr    = 3'd4,
        aluOpSlt   = 3'd5
    } aluOpE;

    // Function actually performed by the ALU
    typedef enum logic [2:0] {
        fnAluAdd = 3'd0,
        fnAluSub = 3'd1,
        fnAluAnd = 3'd2,
        fnAluOr  = 3'd3,
        fnAluNor = 3'd4,
        fnAluSlt = 3'd5
    } aluFnE;

endpackage

/* hw/mainDecoder.sv */
`timescale 1ns/10ps

module mainDecoder
    import exCtrlPkg::*;
    import mipsIsaPkg::*;
(
    input  opcodeE              opcode,
    output logic [wbWidth-1:0]  wb,
    output logic [memWidth-1:0] mem,
    output logic                regDst,
    output logic                aluSrc,
    output aluOpE               aluOp,
    output logic                zeroExt
);

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Nop by default, nothing written and no memory access
        wb      = '0;
        mem     = '0;
        regDst  = 1'b0;
        aluSrc  = 1'b0;
        aluOp   = aluOpAdd;
        zeroExt = 1'b0;

        case (opcode)
            opRtype:
            begin
                // Destination is rd, function from funct
                wb[wbRegWriteBit] = 1'b1;
                regDst            = 1'b1;
                aluOp             = aluOpFunct;
            end
            opAddi:
            begin
                wb[wbRegWriteBit] = 1'b1;
                aluSrc            = 1'b1;
                aluOp             = aluOpAdd;
            end
            opSlti:
            begin
                wb[wbRegWriteBit] = 1'b1;
                aluSrc            = 1'b1;
                aluOp             = aluOpSlt;
            end
            opAndi:
            begin
                // Logical immediates are zero extended
                wb[wbRegWriteBit] = 1'b1;
                aluSrc            = 1'b1;
                zeroExt           = 1'b1;
                aluOp             = aluOpAnd;
            end
            opOri:
            begin
                wb[wbRegWriteBit] = 1'b1;
                aluSrc            = 1'b1;
                zeroExt           = 1'b1;
                aluOp             = aluOpOr;
            end
            opLw:
            begin
                // Address is base plus signed offset
                wb[wbRegWriteBit]  = 1'b1;
                wb[wbMemToRegBit]  = 1'b1;
                mem[memReadBit]    = 1'b1;
                aluSrc             = 1'b1;
                aluOp              = aluOpAdd;
            end
            opSw:
            begin
                mem[memWriteBit] = 1'b1;
                aluSrc           = 1'b1;
                aluOp            = aluOpAdd;
            end
            opBeq:
            begin
                // Subtract so zero flags equality
                mem[memBranchBit] = 1'b1;
                aluOp             = aluOpSub;
            end
            default:
            begin
                // Unknown opcode stays a nop
                wb = '0;
            end
        endcase
    end

endmodule

/* hw/idExRegister.sv */
`timescale 1ns/10ps

module idExRegister
    import exCtrlPkg::*;
    import mipsIsaPkg::*;
#(
    parameter int dataWidth = mipsIsaPkg::dataWidth
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [dataWidth-1:0]    instruction,
    input  logic [dataWidth-1:0]    nextPc,
    input  logic [dataWidth-1:0]    regA,
    input  logic [dataWidth-1:0]    regB,
    input  logic [wbWidth-1:0]      wb,
    input  logic [memWidth-1:0]     mem,
    input  logic                    regDst,
    input  logic                    aluSrc,
    input  aluOpE                   aluOp,
    input  logic                    zeroExt,
    output logic [wbWidth-1:0]      exWb,
    output logic [memWidth-1:0]     exMem,
    output logic                    exRegDst,
    output logic                    exAluSrc,
    output aluOpE                   exAluOp,
    output logic [dataWidth-1:0]    exNextPc,
    output logic [dataWidth-1:0]    exRegA,
    output logic [dataWidth-1:0]    exRegB,
    output logic [dataWidth-1:0]    exImm,
    output logic [regAddrWidth-1:0] exRt,
    output logic [regAddrWidth-1:0] exRd,
    output logic [functWidth-1:0]   exFunct
);

    logic [dataWidth-1:0] immExt;

    ////////////////////////////////////////////////////////////
    // Immediate extension
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Zero fill for andi/ori, sign fill for the rest
        if (zeroExt)
        begin
            immExt = {{(dataWidth-immWidth){1'b0}}, instruction[immWidth-1:0]};
        end
        else
        begin
            immExt = {{(dataWidth-immWidth){instruction[immWidth-1]}},
                      instruction[immWidth-1:0]};
        end
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Cleared slot reads as a nop downstream
            exWb     <= '0;
            exMem    <= '0;
            exRegDst <= 1'b0;
            exAluSrc <= 1'b0;
            exAluOp  <= aluOpAdd;
            exNextPc <= '0;
            exRegA   <= '0;
            exRegB   <= '0;
            exImm    <= '0;
            exRt     <= '0;
            exRd     <= '0;
            exFunct  <= '0;
        end
        else
        begin
            exWb     <= wb;
            exMem    <= mem;
            exRegDst <= regDst;
            exAluSrc <= aluSrc;
            exAluOp  <= aluOp;
            exNextPc <= nextPc;
            exRegA   <= regA;
            exRegB   <= regB;
            exImm    <= immExt;
            // Register fields straight out of the word
            exRt     <= instruction[rtLsb +: regAddrWidth];
            exRd     <= instruction[rdLsb +: regAddrWidth];
            exFunct  <= instruction[functWidth-1:0];
        end
    end

endmodule

/* hw/aluControl.sv */
`timescale 1ns/10ps

module aluControl
    import exCtrlPkg::*;
    import mipsIsaPkg::*;
(
    input  aluOpE                 aluOp,
    input  logic [functWidth-1:0] funct,
    output aluFnE                 aluFn
);

    // Funct field viewed as its encoding
    functE functCode;

    assign functCode = functE'(funct);

    ////////////////////////////////////////////////////////////
    // ALU function select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (aluOp)
            aluOpAdd:   aluFn = fnAluAdd;
            aluOpSub:   aluFn = fnAluSub;
            aluOpAnd:   aluFn = fnAluAnd;
            aluOpOr:    aluFn = fnAluOr;
            aluOpSlt:   aluFn = fnAluSlt;
            aluOpFunct:
            begin
                // R-type, funct picks the operation
                case (functCode)
                    fnAdd:   aluFn = fnAluAdd;
                    fnSub:   aluFn = fnAluSub;
                    fnAnd:   aluFn = fnAluAnd;
                    fnOr:    aluFn = fnAluOr;
                    fnNor:   aluFn = fnAluNor;
                    fnSlt:   aluFn = fnAluSlt;
                    // Unsupported funct falls back to add
                    default: aluFn = fnAluAdd;
                endcase
            end
            default:    aluFn = fnAluAdd;
        endcase
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps

module alu
    import exCtrlPkg::*;
    import mipsIsaPkg::*;
#(
    parameter int dataWidth = mipsIsaPkg::dataWidth
)
(
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluFnE                fn,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    // Signed compare for slt
    logic lessThan;

    assign lessThan = ($signed(a) < $signed(b));

    ////////////////////////////////////////////////////////////
    // Function mux
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (fn)
            fnAluAdd: result = a + b;
            fnAluSub: result = a - b;
            fnAluAnd: result = a & b;
            fnAluOr:  result = a | b;
            fnAluNor: result = ~(a | b);
            // 1 or 0 in the low bit only
            fnAluSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
            default:  result = '0;
        endcase
    end

    // Equality test for beq
    assign zero = (result == '0);

endmodule

/* hw/executeStage.sv */
`timescale 1ns/10ps

module executeStage
    import exCtrlPkg::*;
    import mipsIsaPkg::*;
#(
    parameter int dataWidth = mipsIsaPkg::dataWidth
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [wbWidth-1:0]      exWb,
    input  logic [memWidth-1:0]     exMem,
    input  logic                    exRegDst,
    input  logic                    exAluSrc,
    input  aluOpE                   exAluOp,
    input  logic [dataWidth-1:0]    exNextPc,
    input  logic [dataWidth-1:0]    exRegA,
    input  logic [dataWidth-1:0]    exRegB,
    input  logic [dataWidth-1:0]    exImm,
    input  logic [regAddrWidth-1:0] exRt,
    input  logic [regAddrWidth-1:0] exRd,
    input  logic [functWidth-1:0]   exFunct,
    output logic [wbWidth-1:0]      wbOut,
    output logic [memWidth-1:0]     memOut,
    output logic [dataWidth-1:0]    pcJump,
    output logic [dataWidth-1:0]    aluResult,
    output logic                    aluZero,
    output logic [dataWidth-1:0]    storeData,
    output logic [regAddrWidth-1:0] writeReg
);

    aluFnE                   aluFn;
    logic [dataWidth-1:0]    aluB;
    logic [dataWidth-1:0]    aluOut;
    logic                    aluOutZero;
    logic [regAddrWidth-1:0] destReg;
    logic [dataWidth-1:0]    branchTarget;

    ////////////////////////////////////////////////////////////
    // Operand, destination and branch target
    ////////////////////////////////////////////////////////////

    // Immediate forms take imm as operand B
    assign aluB = exAluSrc ? exImm : exRegB;

    // rd for R-type, rt for everything else
    assign destReg = exRegDst ? exRd : exRt;

    // Word offset relative to the following instruction
    assign branchTarget = exNextPc + (exImm << 2);

    ////////////////////////////////////////////////////////////
    // ALU and its control
    ////////////////////////////////////////////////////////////

    aluControl u_aluControl (
        .aluOp (exAluOp),
        .funct (exFunct),
        .aluFn (aluFn)
    );

    alu #(
        .dataWidth (dataWidth)
    ) u_alu (
        .a      (exRegA),
        .b      (aluB),
        .fn     (aluFn),
        .result (aluOut),
        .zero   (aluOutZero)
    );

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Reset slot leaves the stage as a nop
            wbOut     <= '0;
            memOut    <= '0;
            pcJump    <= '0;
            aluResult <= '0;
            aluZero   <= 1'b0;
            storeData <= '0;
            writeReg  <= '0;
        end
        else
        begin
            wbOut     <= exWb;
            memOut    <= exMem;
            pcJump    <= branchTarget;
            aluResult <= aluOut;
            aluZero   <= aluOutZero;
            // regB carried on for sw
            storeData <= exRegB;
            writeReg  <= destReg;
        end
    end

endmodule

/* hw/executeSubsystem.sv */
`timescale 1ns/10ps

module executeSubsystem
    import exCtrlPkg::*;
    import mipsIsaPkg::*;
#(
    parameter int dataWidth = mipsIsaPkg::dataWidth
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [dataWidth-1:0]    instruction,
    input  logic [dataWidth-1:0]    nextPc,
    input  logic [dataWidth-1:0]    regA,
    input  logic [dataWidth-1:0]    regB,
    output logic [wbWidth-1:0]      wb,
    output logic [memWidth-1:0]     mem,
    output logic [dataWidth-1:0]    pcJump,
    output logic [dataWidth-1:0]    aluResult,
    output logic                    aluZero,
    output logic [dataWidth-1:0]    storeData,
    output logic [regAddrWidth-1:0] writeReg
);

    // Decoder to ID/EX
    logic [wbWidth-1:0]      decWb;
    logic [memWidth-1:0]     decMem;
    logic                    decRegDst;
    logic                    decAluSrc;
    aluOpE                   decAluOp;
    logic                    decZeroExt;

    // ID/EX to execute
    logic [wbWidth-1:0]      exWb;
    logic [memWidth-1:0]     exMem;
    logic                    exRegDst;
    logic                    exAluSrc;
    aluOpE                   exAluOp;
    logic [dataWidth-1:0]    exNextPc;
    logic [dataWidth-1:0]    exRegA;
    logic [dataWidth-1:0]    exRegB;
    logic [dataWidth-1:0]    exImm;
    logic [regAddrWidth-1:0] exRt;
    logic [regAddrWidth-1:0] exRd;
    logic [functWidth-1:0]   exFunct;

    ////////////////////////////////////////////////////////////
    // Decode, same cycle as the ID/EX capture
    ////////////////////////////////////////////////////////////

    mainDecoder u_mainDecoder (
        .opcode  (opcodeE'(instruction[opcodeLsb +: opcodeWidth])),
        .wb      (decWb),
        .mem     (decMem),
        .regDst  (decRegDst),
        .aluSrc  (decAluSrc),
        .aluOp   (decAluOp),
        .zeroExt (decZeroExt)
    );

    idExRegister #(
        .dataWidth (dataWidth)
    ) u_idExRegister (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .nextPc      (nextPc),
        .regA        (regA),
        .regB        (regB),
        .wb          (decWb),
        .mem         (decMem),
        .regDst      (decRegDst),
        .aluSrc      (decAluSrc),
        .aluOp       (decAluOp),
        .zeroExt     (decZeroExt),
        .exWb        (exWb),
        .exMem       (exMem),
        .exRegDst    (exRegDst),
        .exAluSrc    (exAluSrc),
        .exAluOp     (exAluOp),
        .exNextPc    (exNextPc),
        .exRegA      (exRegA),
        .exRegB      (exRegB),
        .exImm       (exImm),
        .exRt        (exRt),
        .exRd        (exRd),
        .exFunct     (exFunct)
    );

    ////////////////////////////////////////////////////////////
    // Execute plus EX/MEM
    ////////////////////////////////////////////////////////////

    executeStage #(
        .dataWidth (dataWidth)
    ) u_executeStage (
        .clk       (clk),
        .rst       (rst),
        .exWb      (exWb),
        .exMem     (exMem),
        .exRegDst  (exRegDst),
        .exAluSrc  (exAluSrc),
        .exAluOp   (exAluOp),
        .exNextPc  (exNextPc),
        .exRegA    (exRegA),
        .exRegB    (exRegB),
        .exImm     (exImm),
        .exRt      (exRt),
        .exRd      (exRd),
        .exFunct   (exFunct),
        .wbOut     (wb),
        .memOut    (mem),
        .pcJump    (pcJump),
        .aluResult (aluResult),
        .aluZero   (aluZero),
        .storeData (storeData),
        .writeReg  (writeReg)
    );

endmodule

/* test/execRefModel.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Expected results for one instruction
////////////////////////////////////////////////////////////

// Extended immediate, zero fill only for andi and ori
function automatic logic [31:0] refImm(input logic [31:0] instr);
    logic [5:0] op;
    op = instr[31:26];
    if (op == opAndi || op == opOri)
    begin
        return {16'h0000, instr[15:0]};
    end
    return {{16{instr[15]}}, instr[15:0]};
endfunction

// True for the opcodes that the decoder knows
function automatic logic refKnownOp(input logic [31:0] instr);
    case (instr[31:26])
        opRtype, opAddi, opSlti, opAndi, opOri, opLw, opSw, opBeq: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Write-back field {regWrite, memToReg}
function automatic logic [1:0] refWb(input logic [31:0] instr);
    case (instr[31:26])
        opRtype, opAddi, opSlti, opAndi, opOri: return 2'b10;
        opLw:    return 2'b11;
        default: return 2'b00;
    endcase
endfunction

// Memory field {memRead, memWrite, branch}
function automatic logic [2:0] refMem(input logic [31:0] instr);
    case (instr[31:26])
        opLw:    return 3'b100;
        opSw:    return 3'b010;
        opBeq:   return 3'b001;
        default: return 3'b000;
    endcase
endfunction

// rd for R-type, rt otherwise
function automatic logic [4:0] refWriteReg(input logic [31:0] instr);
    if (instr[31:26] == opRtype)
    begin
        return instr[15:11];
    end
    return instr[20:16];
endfunction

// Branch target, word offset from the next pc
function automatic logic [31:0] refPcJump(input logic [31:0] instr, input logic [31:0] pc);
    return pc + (refImm(instr) << 2);
endfunction

// ALU result by the ISA rule of each instruction
function automatic logic [31:0] refAluResult(input logic [31:0] instr,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] imm;
    logic [31:0] res;
    imm = refImm(instr);
    case (instr[31:26])
        opRtype:
        begin
            case (instr[5:0])
                fnSub:   res = a - b;
                fnAnd:   res = a & b;
                fnOr:    res = a | b;
                fnNor:   res = ~(a | b);
                fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: res = a + b;
            endcase
        end
        opAddi, opLw, opSw: res = a + imm;
        // Signed compare against the sign-extended immediate
        opSlti:  res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
        opAndi:  res = a & imm;
        opOri:   res = a | imm;
        opBeq:   res = a - b;
        default: res = 32'h0;
    endcase
    return res;
endfunction

`endif

/* test/execTb.sv */
`timescale 1ns/10ps

module execTb
    import mipsIsaPkg::*;
    import exCtrlPkg::*;
;

    localparam int clkPeriod    = 40;
    localparam int resetCycles  = 2;
    localparam int drainTimeout = 10;

    logic                    clk;
    logic                    rst;
    logic [dataWidth-1:0]    instruction;
    logic [dataWidth-1:0]    nextPc;
    logic [dataWidth-1:0]    regA;
    logic [dataWidth-1:0]    regB;
    logic [wbWidth-1:0]      wb;
    logic [memWidth-1:0]     mem;
    logic [dataWidth-1:0]    pcJump;
    logic [dataWidth-1:0]    aluResult;
    logic                    aluZero;
    logic [dataWidth-1:0]    storeData;
    logic [regAddrWidth-1:0] writeReg;

    // Expectation delay line, index 0 is the slot being driven
    logic [wbWidth-1:0]      expWb       [0:2];
    logic [memWidth-1:0]     expMem      [0:2];
    logic [dataWidth-1:0]    expPcJump   [0:2];
    logic [dataWidth-1:0]    expAlu      [0:2];
    logic                    expZero     [0:2];
    logic [dataWidth-1:0]    expStore    [0:2];
    logic [regAddrWidth-1:0] expWriteReg [0:2];
    logic                    expAluValid [0:2];
    int                      expTag      [0:2];

    integer seed;
    int     errorCount;
    int     timeoutCount;
    int     issuedCount;
    int     lastCheckedTag;
    logic   checkOn;

    `include "execRefModel.svh"

    executeSubsystem #(
        .dataWidth (dataWidth)
    ) u_executeSubsystem (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .nextPc      (nextPc),
        .regA        (regA),
        .regB        (regB),
        .wb          (wb),
        .mem         (mem),
        .pcJump      (pcJump),
        .aluResult   (aluResult),
        .aluZero     (aluZero),
        .storeData   (storeData),
        .writeReg    (writeReg)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Expectation pipeline and checks
    ////////////////////////////////////////////////////////////

    // Two stages, same as ID/EX plus EX/MEM
    always @(posedge clk)
    begin
        expWb[1]       <= expWb[0];
        expWb[2]       <= expWb[1];
        expMem[1]      <= expMem[0];
        expMem[2]      <= expMem[1];
        expPcJump[1]   <= expPcJump[0];
        expPcJump[2]   <= expPcJump[1];
        expAlu[1]      <= expAlu[0];
        expAlu[2]      <= expAlu[1];
        expZero[1]     <= expZero[0];
        expZero[2]     <= expZero[1];
        expStore[1]    <= expStore[0];
        expStore[2]    <= expStore[1];
        expWriteReg[1] <= expWriteReg[0];
        expWriteReg[2] <= expWriteReg[1];
        expAluValid[1] <= expAluValid[0];
        expAluValid[2] <= expAluValid[1];
        expTag[1]      <= expTag[0];
        expTag[2]      <= expTag[1];
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
        errorCount++;
    endtask

    // Registered outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (checkOn)
        begin
            assert (wb === expWb[2]) else reportMismatch("wb", expWb[2], wb);
            assert (mem === expMem[2]) else reportMismatch("mem", expMem[2], mem);
            assert (pcJump === expPcJump[2])
                else reportMismatch("pcJump", expPcJump[2], pcJump);
            assert (storeData === expStore[2])
                else reportMismatch("storeData", expStore[2], storeData);
            assert (writeReg === expWriteReg[2])
                else reportMismatch("writeReg", expWriteReg[2], writeReg);
            // ALU outputs of unknown opcodes are not defined
            if (expAluValid[2])
            begin
                assert (aluResult === expAlu[2])
                    else reportMismatch("aluResult", expAlu[2], aluResult);
                assert (aluZero === expZero[2])
                    else reportMismatch("aluZero", expZero[2], aluZero);
            end
            lastCheckedTag = expTag[2];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    // Random 16-bit immediate field
    function automatic logic [15:0] randImm();
        logic [31:0] w;
        w = randWord();
        return w[15:0];
    endfunction

    function automatic logic [4:0] regNum();
        logic [31:0] w;
        w = randWord();
        return w[4:0];
    endfunction

    function automatic logic [31:0] makeRtype(input logic [5:0] funct);
        return {opRtype, regNum(), regNum(), regNum(), 5'h00, funct};
    endfunction

    function automatic logic [31:0] makeItype(input logic [5:0] op, input logic [15:0] imm);
        return {op, regNum(), regNum(), imm};
    endfunction

    // Edge operands around sign and carry boundaries
    function automatic logic [31:0] edgeOperand(input int i);
        case (i)
            0:       return 32'h00000000;
            1:       return 32'h7fffffff;
            2:       return 32'h80000000;
            3:       return 32'hffffffff;
            4:       return 32'h00000001;
            default: return 32'h12345678;
        endcase
    endfunction

    function automatic logic [5:0] pickFunct(input int i);
        case (i)
            0:       return fnAdd;
            1:       return fnSub;
            2:       return fnAnd;
            3:       return fnOr;
            4:       return fnNor;
            default: return fnSlt;
        endcase
    endfunction

    // Last four entries are opcodes the decoder does not know
    function automatic logic [5:0] pickOpcode(input int i);
        case (i)
            0:       return opRtype;
            1:       return opAddi;
            2:       return opSlti;
            3:       return opAndi;
            4:       return opOri;
            5:       return opLw;
            6:       return opSw;
            7:       return opBeq;
            8:       return 6'h02;
            9:       return 6'h05;
            10:      return 6'h0f;
            default: return 6'h3f;
        endcase
    endfunction

    // Reset slots, every output zero
    task automatic clearExpectations();
        for (int i = 0; i < 3; i++)
        begin
            expWb[i]       = '0;
            expMem[i]      = '0;
            expPcJump[i]   = '0;
            expAlu[i]      = '0;
            expZero[i]     = 1'b0;
            expStore[i]    = '0;
            expWriteReg[i] = '0;
            // Slot 0 also stands for the cleared ID/EX slot, a nop through the ALU
            expAluValid[i] = (i != 0);
            expTag[i]      = 0;
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic issue(input logic [31:0] instr, input logic [31:0] pc,
                         input logic [31:0] a, input logic [31:0] b);
        instruction    = instr;
        nextPc         = pc;
        regA           = a;
        regB           = b;
        issuedCount++;
        expWb[0]       = refWb(instr);
        expMem[0]      = refMem(instr);
        expPcJump[0]   = refPcJump(instr, pc);
        expAlu[0]      = refAluResult(instr, a, b);
        expZero[0]     = (refAluResult(instr, a, b) == 32'h0);
        expStore[0]    = b;
        expWriteReg[0] = refWriteReg(instr);
        expAluValid[0] = refKnownOp(instr);
        expTag[0]      = issuedCount;
        @(negedge clk);
    endtask

    task automatic applyReset();
        int cycles;
        rst = 1'b1;
        cycles = 0;
        while (cycles < resetCycles)
        begin
            @(posedge clk);
            checkOn = 1'b1;
            cycles++;
        end
        @(negedge clk);
        rst = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////

    task automatic runRtype();
        for (int f = 0; f < 6; f++)
        begin
            for (int i = 0; i < 6; i++)
            begin
                issue(makeRtype(pickFunct(f)), randWord(), edgeOperand(i), edgeOperand(5 - i));
            end
            // Equal operands, sub gives zero
            issue(makeRtype(pickFunct(f)), randWord(), edgeOperand(f), edgeOperand(f));
            for (int i = 0; i < 4; i++)
            begin
                issue(makeRtype(pickFunct(f)), randWord(), randWord(), randWord());
            end
        end
    endtask

    task automatic runImmediate();
        logic [5:0]  ops [0:3];
        logic [15:0] imms [0:4];
        ops  = '{opAddi, opSlti, opAndi, opOri};
        imms = '{16'h8000, 16'hffff, 16'hfff0, 16'h7fff, 16'h0001};
        for (int o = 0; o < 4; o++)
        begin
            for (int i = 0; i < 5; i++)
            begin
                issue(makeItype(ops[o], imms[i]), randWord(), edgeOperand(i), randWord());
            end
            for (int i = 0; i < 3; i++)
            begin
                issue(makeItype(ops[o], randImm()), randWord(), randWord(), randWord());
            end
        end
    endtask

    task automatic runMemory();
        logic [15:0] offsets [0:3];
        offsets = '{16'hfffc, 16'h8000, 16'h0010, 16'h0000};
        for (int i = 0; i < 4; i++)
        begin
            issue(makeItype(opLw, offsets[i]), randWord(), randWord(), randWord());
            issue(makeItype(opSw, offsets[i]), randWord(), randWord(), randWord());
        end
        issue(makeItype(opLw, randImm()), randWord(), randWord(), randWord());
        issue(makeItype(opSw, randImm()), randWord(), randWord(), randWord());
    endtask

    task automatic runBranch();
        logic [31:0] a;
        a = randWord();
        // Taken with a backward offset
        issue(makeItype(opBeq, 16'hfff8), 32'h00400100, a, a);
        issue(makeItype(opBeq, 16'h0020), 32'h00400104, a, ~a);
        issue(makeItype(opBeq, 16'h8000), 32'h00000010, 32'h0, 32'h0);
        for (int i = 0; i < 4; i++)
        begin
            a = randWord();
            issue(makeItype(opBeq, randImm()), randWord(), a, (i % 2 == 0) ? a : randWord());
        end
    endtask

    // Back-to-back mix, nops included
    task automatic runMixed();
        logic [31:0] w;
        logic [31:0] a;
        logic [5:0]  op;
        for (int i = 0; i < 60; i++)
        begin
            w  = randWord();
            op = pickOpcode(w[7:4] % 12);
            a  = randWord();
            if (op == opRtype)
            begin
                issue(makeRtype(pickFunct(w[11:8] % 6)), randWord(), a, w[0] ? a : randWord());
            end
            else
            begin
                issue(makeItype(op, randImm()), randWord(), a, w[0] ? a : randWord());
            end
        end
    endtask

    task automatic drainPipeline();
        int cycles;
        cycles = 0;
        while (lastCheckedTag != issuedCount && cycles < drainTimeout)
        begin
            @(posedge clk);
            cycles++;
        end
        if (lastCheckedTag != issuedCount)
        begin
            $display("Timeout: the result of the last instruction never reached the outputs");
            timeoutCount++;
        end
    endtask

    initial
    begin
        seed           = 32'h29afa98b;
        errorCount     = 0;
        timeoutCount   = 0;
        issuedCount    = 0;
        lastCheckedTag = 0;
        checkOn        = 1'b0;
        rst            = 1'b1;
        instruction    = '0;
        nextPc         = '0;
        regA           = '0;
        regB           = '0;
        clearExpectations();
        applyReset();
        runRtype();
        runImmediate();
        runMemory();
        runBranch();
        runMixed();
        drainPipeline();
        $display("Instructions: %0d, errors: %0d, timeouts: %0d",
                 issuedCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+test
hw/mipsIsaPkg.sv
hw/exCtrlPkg.sv
hw/mainDecoder.sv
hw/idExRegister.sv
hw/aluControl.sv
hw/alu.sv
hw/executeStage.sv
hw/executeSubsystem.sv
test/execTb.sv
